// ==== list.f ====
acq_pkg.sv
cfg_regs.sv
adc_capture.sv
dac_mixer.sv
acq_top.sv
tb_assert.sv
tb_checker.sv
tb_top.sv

// ==== Makefile ====
TOP = tb_top

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f

run: build
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// ==== tb_top.sv ====
// testbench top for the acquisition datapath
// clock, reset, seeded random stimulus and the test sequence
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  import acq_pkg::*;

  localparam int ACK_LIMIT  = 20;  // cycles allowed per ack edge
  localparam int MODE_SMALL = 0;   // sums always fit
  localparam int MODE_FULL  = 1;   // full range, saturates often
  localparam int MODE_MAX   = 2;   // both inputs at positive full scale
  localparam int MODE_MIN   = 3;   // both inputs at negative full scale

  logic                  adc_clk;
  logic                  reset_i;
  sample_pair_t          adc_dat;
  sample_pair_t          gen_dat;
  sample_pair_t          pid_dat;
  logic                  cfg_req;
  cfg_req_t              cfg_bus;
  logic                  cfg_ack;
  logic [CFG_DATA_W-1:0] cfg_rdata;
  sample_pair_t          acq_dat;
  sample_pair_t          dac_dat;
  logic                  dac_reset;
  logic                  check_en;     // checker compares while set
  logic [31:0]           rdata;        // last config read value
  int                    seed;
  int                    err_total;
  int                    test_cnt;
  int                    assert_fails;
  bit                    hung;         // a handshake timed out

  initial adc_clk = 1'b0;
  always #20 adc_clk = ~adc_clk;  // 40 ns period

  acq_top uut (
    .adc_clk     (adc_clk  ),
    .reset_i     (reset_i  ),
    .adc_dat_i   (adc_dat  ),
    .gen_dat_i   (gen_dat  ),
    .pid_dat_i   (pid_dat  ),
    .cfg_req_i   (cfg_req  ),
    .cfg_bus_i   (cfg_bus  ),
    .cfg_ack_o   (cfg_ack  ),
    .cfg_rdata_o (cfg_rdata),
    .acq_dat_o   (acq_dat  ),
    .dac_dat_o   (dac_dat  ),
    .dac_reset_o (dac_reset)
  );

  tb_checker chk (
    .adc_clk     (adc_clk  ),
    .reset_i     (reset_i  ),
    .check_en_i  (check_en ),
    .adc_dat_i   (adc_dat  ),
    .gen_dat_i   (gen_dat  ),
    .pid_dat_i   (pid_dat  ),
    .cfg_req_i   (cfg_req  ),
    .cfg_bus_i   (cfg_bus  ),
    .cfg_ack_i   (cfg_ack  ),
    .cfg_rdata_i (cfg_rdata),
    .acq_dat_i   (acq_dat  ),
    .dac_dat_i   (dac_dat  ),
    .dac_reset_i (dac_reset),
    .err_total_o (err_total),
    .test_cnt_o  (test_cnt )
  );

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic sample_t rand_small();
    logic [31:0] r;
    r = $random(seed);
    return {r[12], r[12:0]};  // 13 bit signed range
  endfunction

  function automatic sample_t rand_full();
    logic [31:0] r;
    r = $random(seed);
    return r[13:0];
  endfunction

  // new adc, generator and controller words
  task automatic drive_data(input int mode);
    logic [31:0] r;
    r       = $random(seed);
    adc_dat = r[27:0];  // adc is always random
    case (mode)
      MODE_SMALL:
      begin
        gen_dat.ch_a = rand_small();
        gen_dat.ch_b = rand_small();
        pid_dat.ch_a = rand_small();
        pid_dat.ch_b = rand_small();
      end
      MODE_MAX:
      begin
        gen_dat = {14'sh1fff, 14'sh1fff};
        pid_dat = {14'sh1fff, 14'sh1fff};
      end
      MODE_MIN:
      begin
        gen_dat = {14'sh2000, 14'sh2000};
        pid_dat = {14'sh2000, 14'sh2000};
      end
      default:
      begin
        gen_dat.ch_a = rand_full();
        gen_dat.ch_b = rand_full();
        pid_dat.ch_a = rand_full();
        pid_dat.ch_b = rand_full();
      end
    endcase
  endtask

  task automatic run_cycles(input int n, input int mode);
    repeat (n)
    begin
      @(posedge adc_clk);
      #2;  // drive after the edge
      drive_data(mode);
    end
  endtask

  // one four-phase transfer, rd is sampled while ack is high
  task automatic cfg_access(input logic [CFG_ADDR_W-1:0] a, input logic [31:0] d,
                            input logic we, output logic [31:0] rd);
    int cnt;
    rd = '0;
    if (!hung)
    begin
      @(posedge adc_clk);
      #2;
      cfg_bus.addr  = a;
      cfg_bus.wdata = d;
      cfg_bus.we    = we;
      cfg_req       = 1'b1;
      cnt = 0;
      while (!cfg_ack && cnt < ACK_LIMIT)  // wait for ack rise
      begin
        @(posedge adc_clk);
        #2;
        cnt++;
      end
      if (!cfg_ack)
      begin
        $display("error: no config acknowledge within %0d cycles", ACK_LIMIT);
        hung = 1'b1;
      end
      rd      = cfg_rdata;
      cfg_req = 1'b0;  // release
      cnt = 0;
      while (cfg_ack && cnt < ACK_LIMIT)  // wait for ack fall
      begin
        @(posedge adc_clk);
        #2;
        cnt++;
      end
      if (cfg_ack)
      begin
        $display("error: config acknowledge stuck high after request release");
        hung = 1'b1;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    seed     = 32'h5c03;
    reset_i  = 1'b1;
    adc_dat  = '0;
    gen_dat  = '0;
    pid_dat  = '0;
    cfg_req  = 1'b0;
    cfg_bus  = '0;
    check_en = 1'b0;
    hung     = 1'b0;

    chk.start_test("reset");
    @(posedge adc_clk);
    #2;
    check_en = 1'b1;  // model is reset on that edge too
    repeat (4)
    begin
      @(posedge adc_clk);
      #2;
    end
    reset_i = 1'b0;  // 5 cycles held
    run_cycles(3, MODE_SMALL);
    chk.finish_test();

    chk.start_test("mixing");
    run_cycles(200, MODE_SMALL);
    chk.finish_test();

    chk.start_test("saturation");
    run_cycles(3, MODE_MAX);
    run_cycles(3, MODE_MIN);
    run_cycles(200, MODE_FULL);
    chk.finish_test();

    chk.start_test("adc_capture");
    run_cycles(100, MODE_FULL);
    chk.finish_test();

    chk.start_test("loopback");
    cfg_access(CFG_CTRL_ADDR, 32'd1, 1'b1, rdata);
    cfg_access(CFG_CTRL_ADDR, 32'd0, 1'b0, rdata);
    chk.check_value("ctrl readback on", 32'd1, rdata);
    run_cycles(100, MODE_FULL);
    cfg_access(CFG_CTRL_ADDR, 32'd0, 1'b1, rdata);
    cfg_access(CFG_CTRL_ADDR, 32'd0, 1'b0, rdata);
    chk.check_value("ctrl readback off", 32'd0, rdata);
    run_cycles(50, MODE_FULL);
    chk.finish_test();

    // loopback on, then poke an unmapped register with 0
    chk.start_test("unmapped");
    cfg_access(CFG_CTRL_ADDR, 32'd1, 1'b1, rdata);
    cfg_access(4'h5, 32'd0, 1'b1, rdata);
    chk.check_value("unmapped write data", 32'd0, rdata);
    cfg_access(4'h5, 32'd0, 1'b0, rdata);
    chk.check_value("unmapped readback", 32'd0, rdata);
    cfg_access(CFG_CTRL_ADDR, 32'd0, 1'b0, rdata);
    chk.check_value("ctrl unchanged", 32'd1, rdata);
    run_cycles(30, MODE_FULL);
    cfg_access(CFG_CTRL_ADDR, 32'd0, 1'b1, rdata);
    run_cycles(10, MODE_FULL);
    check_en = 1'b0;
    chk.finish_test();

    assert_fails = uut.i_cfg_regs.i_tb_assert.fail_cnt;
    $display("tests %0d, errors %0d, assertion failures %0d",
             test_cnt, err_total, assert_fails);
    if (err_total == 0 && assert_fails == 0 && !hung)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule : tb_top

`default_nettype wire

// ==== tb_checker.sv ====
// reference model for the acquisition datapath
// watches the dut ports, compares every cycle and counts errors per test
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  wire                            adc_clk,
  input  wire                            reset_i,
  input  wire                            check_en_i,   // compare enable
  input  wire acq_pkg::sample_pair_t     adc_dat_i,
  input  wire acq_pkg::sample_pair_t     gen_dat_i,
  input  wire acq_pkg::sample_pair_t     pid_dat_i,
  input  wire                            cfg_req_i,
  input  wire acq_pkg::cfg_req_t         cfg_bus_i,
  input  wire                            cfg_ack_i,
  input  wire [acq_pkg::CFG_DATA_W-1:0]  cfg_rdata_i,
  input  wire acq_pkg::sample_pair_t     acq_dat_i,
  input  wire acq_pkg::sample_pair_t     dac_dat_i,
  input  wire                            dac_reset_i,
  output int                             err_total_o,
  output int                             test_cnt_o
);

  import acq_pkg::*;

  sample_pair_t mix_m;      // first register after the sum
  sample_pair_t dac_m;      // dac output
  sample_pair_t adc_m;      // filled adc word
  sample_pair_t acq_m;      // acquisition output
  logic         ack_m;
  logic         loop_m;
  logic         ctrl_next;  // control bit after the current request
  logic [31:0]  rdata_m;
  logic         rst_m;
  string        test_name = "none";
  int           test_err  = 0;
  int           test_cyc  = 0;
  int           err_total = 0;
  int           test_cnt  = 0;

  assign err_total_o = err_total;
  assign test_cnt_o  = test_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // model arithmetic
  ////////////////////////////////////////////////////////////////////////////

  function automatic sample_t clamp_sum(input sample_t a, input sample_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return sample_t'(s);
  endfunction

  // low two bits become copies of bit 2
  function automatic sample_t fill_low(input sample_t raw);
    sample_t v;
    v = raw & ~sample_t'(3);
    if (raw[2])
      v = v | sample_t'(3);
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // test bookkeeping, also called from the testbench top
  ////////////////////////////////////////////////////////////////////////////

  task automatic start_test(input string name);
    test_name = name;
    test_err  = 0;
    test_cyc  = 0;
    test_cnt++;
  endtask

  task automatic finish_test();
    $display("test %s: %0d cycles, %0d errors", test_name, test_cyc, test_err);
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp)
    begin
      $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
      test_err++;
      err_total++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // model pipelines, inputs are stable at the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk)
  begin
    rst_m <= reset_i;  // dac reset follows with one edge
    if (reset_i)
    begin
      mix_m   <= '0;
      dac_m   <= '0;
      adc_m   <= '0;
      acq_m   <= '0;
      ack_m   <= 1'b0;
      loop_m  <= 1'b0;
      rdata_m <= '0;
    end
    else
    begin
      mix_m.ch_a <= clamp_sum(gen_dat_i.ch_a, pid_dat_i.ch_a);
      mix_m.ch_b <= clamp_sum(gen_dat_i.ch_b, pid_dat_i.ch_b);
      dac_m      <= mix_m;
      adc_m.ch_a <= fill_low(adc_dat_i.ch_a);
      adc_m.ch_b <= fill_low(adc_dat_i.ch_b);
      acq_m      <= loop_m ? mix_m : adc_m;  // loopback shows the dac word
      if (cfg_req_i && !ack_m)
      begin
        ack_m     <= 1'b1;  // new request
        ctrl_next  = loop_m;
        if (cfg_bus_i.addr == CFG_CTRL_ADDR && cfg_bus_i.we)
          ctrl_next = cfg_bus_i.wdata[0];
        loop_m  <= ctrl_next;
        rdata_m <= (cfg_bus_i.addr == CFG_CTRL_ADDR) ? {31'b0, ctrl_next} : 32'b0;
      end
      else if (ack_m && !cfg_req_i)
        ack_m <= 1'b0;
    end
  end

  // compare half a cycle later, outputs settled
  always @(negedge adc_clk)
  begin
    if (check_en_i)
    begin
      test_cyc++;
      check_value("dac_reset_o", {31'b0, rst_m}, {31'b0, dac_reset_i});
      check_value("dac_dat_o", {4'b0, dac_m}, {4'b0, dac_dat_i});
      check_value("acq_dat_o", {4'b0, acq_m}, {4'b0, acq_dat_i});
      check_value("cfg_ack_o", {31'b0, ack_m}, {31'b0, cfg_ack_i});
      if (ack_m)
        check_value("cfg_rdata_o", rdata_m, cfg_rdata_i);  // valid with ack only
    end
  end

endmodule : tb_checker

`default_nettype wire

// ==== tb_assert.sv ====
// handshake and reset assertions for the config register block
`timescale 1ns/1ps
`default_nettype none

module tb_assert (
  input wire adc_clk,
  input wire reset_i,
  input wire req_i,    // config request
  input wire ack_i     // config acknowledge
);

  int fail_cnt = 0;  // read by the testbench top

  // ack only rises on a pending request
  ack_rise_on_req: assert property (@(posedge adc_clk) disable iff (reset_i)
    $rose(ack_i) |-> $past(req_i))
    else
    begin
      fail_cnt++;
      $error("config ack rose without a request");
    end

  // release seen, ack drops on the next edge
  ack_fall_after_req: assert property (@(posedge adc_clk) disable iff (reset_i)
    (ack_i && !req_i) |=> !ack_i)
    else
    begin
      fail_cnt++;
      $error("config ack still high one cycle after request release");
    end

  ack_low_after_reset: assert property (@(posedge adc_clk) $past(reset_i) |-> !ack_i)
    else
    begin
      fail_cnt++;
      $error("config ack high after reset");
    end

endmodule : tb_assert

bind cfg_regs tb_assert i_tb_assert (
  .adc_clk (adc_clk  ),
  .reset_i (reset_i  ),
  .req_i   (cfg_req_i),
  .ack_i   (cfg_ack_o)
);

`default_nettype wire

// ==== acq_top.sv ====
// fast analog datapath top
// config registers beside the adc capture and dac mixing pipelines
`timescale 1ns/1ps
`default_nettype none

module acq_top (
  // clock and reset
  input  wire                              adc_clk,      // adc clock
  input  wire                              reset_i,      // sync reset, active high
  // adc
  input  wire acq_pkg::sample_pair_t       adc_dat_i,    // raw adc pair
  // generator and controller
  input  wire acq_pkg::sample_pair_t       gen_dat_i,    // generator samples
  input  wire acq_pkg::sample_pair_t       pid_dat_i,    // controller samples
  // config bus
  input  wire                              cfg_req_i,    // request
  input  wire acq_pkg::cfg_req_t           cfg_bus_i,    // addr, wdata, we
  output logic                             cfg_ack_o,    // acknowledge
  output logic [acq_pkg::CFG_DATA_W-1:0]   cfg_rdata_o,  // read data
  // acquisition stream
  output acq_pkg::sample_pair_t            acq_dat_o,    // toward the scope
  // dac
  output acq_pkg::sample_pair_t            dac_dat_o,    // dac data
  output logic                             dac_reset_o   // dac reset
);

  import acq_pkg::*;

  logic         loop_en;  // digital loopback from control register
  sample_pair_t mix_dat;  // mixer stage 1, loopback source

  ////////////////////////////////////////////////////////////////////////////
  // configuration
  ////////////////////////////////////////////////////////////////////////////

  cfg_regs i_cfg_regs (
    .adc_clk     (adc_clk    ),
    .reset_i     (reset_i    ),
    .cfg_req_i   (cfg_req_i  ),
    .cfg_bus_i   (cfg_bus_i  ),
    .cfg_ack_o   (cfg_ack_o  ),
    .cfg_rdata_o (cfg_rdata_o),
    .loop_en_o   (loop_en    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // adc capture and loopback
  ////////////////////////////////////////////////////////////////////////////

  adc_capture i_adc_capture (
    .adc_clk   (adc_clk  ),
    .reset_i   (reset_i  ),
    .adc_dat_i (adc_dat_i),
    .dac_dat_i (mix_dat  ),  // same word the dac gets one edge later
    .loop_en_i (loop_en  ),
    .acq_dat_o (acq_dat_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // dac mixing
  ////////////////////////////////////////////////////////////////////////////

  dac_mixer i_dac_mixer (
    .adc_clk     (adc_clk    ),
    .reset_i     (reset_i    ),
    .gen_dat_i   (gen_dat_i  ),
    .pid_dat_i   (pid_dat_i  ),
    .dac_dat_o   (dac_dat_o  ),
    .mix_dat_o   (mix_dat    ),
    .dac_reset_o (dac_reset_o)
  );

endmodule : acq_top

`default_nettype wire

// ==== dac_mixer.sv ====
// dac mixing stage
// sums generator and controller samples per channel, saturates to 14 bits,
// registers twice toward the dac and registers the dac reset
`timescale 1ns/1ps
`default_nettype none

module dac_mixer (
  input  wire                          adc_clk,      // adc clock
  input  wire                          reset_i,      // sync reset, active high
  input  wire acq_pkg::sample_pair_t   gen_dat_i,    // generator samples
  input  wire acq_pkg::sample_pair_t   pid_dat_i,    // controller samples
  output acq_pkg::sample_pair_t        dac_dat_o,    // stage 2, to the dac pins
  output acq_pkg::sample_pair_t        mix_dat_o,    // stage 1, saturated sum
  output logic                         dac_reset_o   // dac reset, registered
);

  import acq_pkg::*;

  sample_t [N_CH-1:0] gen_arr;  // [1] ch_a, [0] ch_b
  sample_t [N_CH-1:0] pid_arr;
  sample_t [N_CH-1:0] sat_arr;  // clamped sums
  sample_pair_t       mix_q;    // stage 1
  sample_pair_t       dac_q;    // stage 2
  logic               dac_rst_q;

  ////////////////////////////////////////////////////////////////////////////
  // sum and saturation
  ////////////////////////////////////////////////////////////////////////////

  // add with one guard bit; top two bits differ on overflow
  function automatic sample_t sat_sum(input sample_t a, input sample_t b);
    logic signed [SUM_W-1:0] sum;
    sum = SUM_W'(a) + SUM_W'(b);  // sign extended operands
    if (sum[SUM_W-1] != sum[SUM_W-2])
      return {sum[SUM_W-1], {(DAC_W-1){~sum[SUM_W-1]}}};  // full scale, sign kept
    return sum[DAC_W-1:0];
  endfunction

  assign gen_arr = gen_dat_i;
  assign pid_arr = pid_dat_i;

  always_comb
  begin
    for (int i = 0; i < N_CH; i++)
      sat_arr[i] = sat_sum(gen_arr[i], pid_arr[i]);
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  // stage 1, also feeds the loopback path
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      mix_q <= '0;
    else
      mix_q <= sample_pair_t'(sat_arr);
  end

  // stage 2, output register at the dac
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      dac_q <= '0;
    else
      dac_q <= mix_q;
  end

  // dac held in reset with the datapath, released one edge after
  always_ff @(posedge adc_clk)
  begin
    dac_rst_q <= reset_i;
  end

  assign mix_dat_o   = mix_q;
  assign dac_dat_o   = dac_q;
  assign dac_reset_o = dac_rst_q;

endmodule : dac_mixer

`default_nettype wire

// ==== adc_capture.sv ====
// adc capture stage
// registers the raw adc pair with lsb fill, then selects adc or dac data
`timescale 1ns/1ps
`default_nettype none

module adc_capture (
  input  wire                          adc_clk,    // adc clock
  input  wire                          reset_i,    // sync reset, active high
  input  wire acq_pkg::sample_pair_t   adc_dat_i,  // raw adc pair, already parallel
  input  wire acq_pkg::sample_pair_t   dac_dat_i,  // mixer stage 1, for loopback
  input  wire                          loop_en_i,  // digital loopback enable
  output acq_pkg::sample_pair_t        acq_dat_o   // acquisition stream
);

  import acq_pkg::*;

  sample_t [N_CH-1:0] adc_raw;   // [1] ch_a, [0] ch_b
  sample_t [N_CH-1:0] adc_fill;  // low bits replaced
  sample_pair_t       adc_q;     // stage 1
  sample_pair_t       acq_q;     // stage 2

  // low bits are noisy on the converter, copy the first good bit down
  function automatic sample_t fill_lsb(input sample_t raw);
    return {raw[ADC_W-1:FILL_LSB], {FILL_LSB{raw[FILL_LSB]}}};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stage 1, input register
  ////////////////////////////////////////////////////////////////////////////

  assign adc_raw = adc_dat_i;  // pair viewed as channel array

  always_comb
  begin
    for (int i = 0; i < N_CH; i++)
      adc_fill[i] = fill_lsb(adc_raw[i]);  // per channel
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      adc_q <= '0;
    else
      adc_q <= sample_pair_t'(adc_fill);
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2, loopback select
  ////////////////////////////////////////////////////////////////////////////

  // loopback takes the mixer word, which is already one register deep
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      acq_q <= '0;
    else if (loop_en_i)
      acq_q <= dac_dat_i;  // dac words into the scope path
    else
      acq_q <= adc_q;      // captured adc words
  end

  assign acq_dat_o = acq_q;

endmodule : adc_capture

`default_nettype wire

// ==== cfg_regs.sv ====
// config register block on a four-phase req/ack handshake
// holds the control register with the digital loopback enable
`timescale 1ns/1ps
`default_nettype none

module cfg_regs (
  input  wire                              adc_clk,      // adc clock
  input  wire                              reset_i,      // sync reset, active high
  input  wire                              cfg_req_i,    // request level
  input  wire acq_pkg::cfg_req_t           cfg_bus_i,    // addr, wdata, we
  output logic                             cfg_ack_o,    // acknowledge level
  output logic [acq_pkg::CFG_DATA_W-1:0]   cfg_rdata_o,  // valid while ack high
  output logic                             loop_en_o     // digital loopback
);

  import acq_pkg::*;

  logic                  ack_q;      // handshake state
  logic                  loop_q;     // loopback bit of the control register
  logic [CFG_DATA_W-1:0] rdata_q;    // read data, captured with the request
  logic                  req_new;    // req high, not yet acknowledged
  logic                  ctrl_hit;   // address decodes to control register
  logic                  ctrl_wr;    // write to control register this cycle
  logic [CFG_DATA_W-1:0] ctrl_word;  // control register after this request

  ////////////////////////////////////////////////////////////////////////////
  // request detection and decode
  ////////////////////////////////////////////////////////////////////////////

  // rising request, seen against the ack flag
  assign req_new  = cfg_req_i & ~ack_q;
  assign ctrl_hit = (cfg_bus_i.addr == CFG_CTRL_ADDR);
  assign ctrl_wr  = req_new & ctrl_hit & cfg_bus_i.we;

  // read value reflects a write in the same request
  always_comb
  begin
    ctrl_word = '0;  // unimplemented bits read zero
    if (ctrl_wr)
      ctrl_word[CTRL_LOOP_BIT] = cfg_bus_i.wdata[CTRL_LOOP_BIT];
    else
      ctrl_word[CTRL_LOOP_BIT] = loop_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // handshake and registers
  ////////////////////////////////////////////////////////////////////////////

  // ack rises one edge after req, falls one edge after req drops
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      ack_q <= 1'b0;
    else if (req_new)
      ack_q <= 1'b1;  // request taken
    else if (ack_q && !cfg_req_i)
      ack_q <= 1'b0;  // master released req
  end

  // loopback enable, active from the cycle ack rises
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      loop_q <= 1'b0;
    else if (ctrl_wr)
      loop_q <= cfg_bus_i.wdata[CTRL_LOOP_BIT];
  end

  // read data, other addresses return zero
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      rdata_q <= '0;
    else if (req_new)
      rdata_q <= ctrl_hit ? ctrl_word : '0;
  end

  assign cfg_ack_o   = ack_q;
  assign cfg_rdata_o = rdata_q;
  assign loop_en_o   = loop_q;

endmodule : cfg_regs

`default_nettype wire

// ==== acq_pkg.sv ====
// acquisition datapath definitions
// sample widths, channel pair types and the config bus register map
`default_nettype none

package acq_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sample widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADC_W    = 14;  // raw adc word
  localparam int DAC_W    = 14;  // dac word
  localparam int SUM_W    = 15;  // generator + controller sum, one guard bit
  localparam int N_CH     = 2;   // analog channels
  localparam int FILL_LSB = 2;   // unreliable adc lsbs, filled from the next bit

  ////////////////////////////////////////////////////////////////////////////
  // config bus and register map
  ////////////////////////////////////////////////////////////////////////////

  localparam int CFG_ADDR_W = 4;
  localparam int CFG_DATA_W = 32;

  // control register
  localparam logic [CFG_ADDR_W-1:0] CFG_CTRL_ADDR = '0;
  localparam int CTRL_LOOP_BIT = 0;  // digital loopback enable

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  // one two's complement sample, same width on adc and dac side
  typedef logic signed [DAC_W-1:0] sample_t;

  // channel pair, ch_a sits in the upper half
  typedef struct packed {
    sample_t ch_a;
    sample_t ch_b;
  } sample_pair_t;

  // request side of the config bus, held stable while req is high
  typedef struct packed {
    logic [CFG_ADDR_W-1:0] addr;   // word address
    logic [CFG_DATA_W-1:0] wdata;  // write data
    logic                  we;     // 1 write, 0 read
  } cfg_req_t;

endpackage : acq_pkg

`default_nettype wire
